// File: Bender.yml
package:
  name: operand_fetch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/operand_pkg.sv
      - logic/mux_tree.sv
      - logic/mux_onehot.sv
      - logic/register_file.sv
      - logic/bypass_select.sv
      - logic/operand_fetch.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_operand_fetch.sv

// File: include/operand_fetch_defines.svh
`ifndef OPERAND_FETCH_DEFINES_SVH
`define OPERAND_FETCH_DEFINES_SVH

// ########################################
// architectural register file geometry
// ########################################

// registers 0..7, register 0 reads as zero
`define OF_NUM_REGS 8

// register address width, log2 of OF_NUM_REGS
`define OF_REG_ADDR_W 3

// ########################################
// datapath
// ########################################

// operand and immediate width
`define OF_DATA_W 32

`endif

// File: logic/bypass_select.sv
`timescale 1ns/1ps

`include "operand_fetch_defines.svh"

// picks one operand from the youngest matching source
module bypass_select (
    input  logic [`OF_REG_ADDR_W-1:0] src,
    input  operand_pkg::fwd_t         ex_fwd,
    input  operand_pkg::fwd_t         wb,
    input  logic [`OF_DATA_W-1:0]     rf_data,
    input  logic                      alt_en,
    input  logic [`OF_DATA_W-1:0]     alt_data,
    output logic [`OF_DATA_W-1:0]     operand
);

    // one-hot slot order
    localparam int SLOT_EX  = 0;
    localparam int SLOT_WB  = 1;
    localparam int SLOT_RF  = 2;
    localparam int SLOT_ALT = 3;
    localparam int NUM_SRC  = 4;

    // ########################################
    // match detection
    // ########################################

    logic src_live;
    logic ex_hit;
    logic wb_hit;

    // register 0 never takes a forward
    assign src_live = (src != '0);
    assign ex_hit   = src_live && ex_fwd.valid && (ex_fwd.dst == src);
    assign wb_hit   = src_live && wb.valid && (wb.dst == src);

    // ########################################
    // priority to one-hot
    // ########################################

    logic [NUM_SRC-1:0] sel;

    always_comb begin
        sel = '0;
        if (alt_en) begin
            sel[SLOT_ALT] = 1'b1;
        end else if (ex_hit) begin
            sel[SLOT_EX] = 1'b1;
        end else if (wb_hit) begin
            sel[SLOT_WB] = 1'b1;
        end else begin
            sel[SLOT_RF] = 1'b1;
        end
    end

    logic [NUM_SRC*`OF_DATA_W-1:0] candidates;

    assign candidates = {alt_data, rf_data, wb.data, ex_fwd.data};

    mux_onehot #(
        .NUM_INPUTS(NUM_SRC),
        .DATA_WIDTH(`OF_DATA_W)
    ) pick_i (
        .in (candidates),
        .sel(sel),
        .out(operand)
    );

endmodule

// File: logic/mux_onehot.sv
`timescale 1ns/1ps

// one-hot select mux built as and-or, same behavior as a shared tristate bus
module mux_onehot #(
    parameter int NUM_INPUTS = 2,
    parameter int DATA_WIDTH = 1
) (
    input  logic [NUM_INPUTS*DATA_WIDTH-1:0] in,
    input  logic [NUM_INPUTS-1:0]            sel,
    output logic [DATA_WIDTH-1:0]            out
);

    logic [DATA_WIDTH-1:0] gated [NUM_INPUTS];

    // each driver only contributes while its select is high
    for (genvar j = 0; j < NUM_INPUTS; j++) begin : g_drive
        assign gated[j] = in[j*DATA_WIDTH +: DATA_WIDTH] & {DATA_WIDTH{sel[j]}};
    end

    // no select high gives zero rather than a floating bus
    always_comb begin
        out = '0;
        for (int j = 0; j < NUM_INPUTS; j++) begin
            out = out | gated[j];
        end
    end

endmodule

// File: logic/mux_tree.sv
`timescale 1ns/1ps

// binary select mux, word packed input, one bit tree per data bit
module mux_tree #(
    parameter int SEL_WIDTH  = 1,
    parameter int DATA_WIDTH = 1
) (
    input  logic [(2**SEL_WIDTH)*DATA_WIDTH-1:0] in,
    input  logic [SEL_WIDTH-1:0]                 sel,
    output logic [DATA_WIDTH-1:0]                out
);

    localparam int NUM_WORDS = 2**SEL_WIDTH;

    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_slice
        logic [NUM_WORDS-1:0] bit_vec;

        // gather bit i of every word into one vector
        for (genvar j = 0; j < NUM_WORDS; j++) begin : g_gather
            assign bit_vec[j] = in[DATA_WIDTH*j + i];
        end

        mux_tree_bit #(
            .SEL_WIDTH(SEL_WIDTH)
        ) bit_mux_i (
            .in (bit_vec),
            .sel(sel),
            .out(out[i])
        );
    end

endmodule

// single bit tree, resolves the low select bits first
module mux_tree_bit #(
    parameter int SEL_WIDTH = 1
) (
    input  logic [(2**SEL_WIDTH)-1:0] in,
    input  logic [SEL_WIDTH-1:0]      sel,
    output logic                      out
);

    if (SEL_WIDTH % 2 == 0) begin : g_layer4
        logic [(2**(SEL_WIDTH-2))-1:0] layer_out;

        for (genvar k = 0; k < 2**(SEL_WIDTH-2); k++) begin : g_mux4
            logic [3:0] quad;
            assign quad         = in[4*k +: 4];
            assign layer_out[k] = quad[sel[1:0]];
        end

        if (SEL_WIDTH == 2) begin : g_leaf
            assign out = layer_out[0];
        end else begin : g_next
            mux_tree_bit #(
                .SEL_WIDTH(SEL_WIDTH-2)
            ) sub_i (
                .in (layer_out),
                .sel(sel[SEL_WIDTH-1:2]),
                .out(out)
            );
        end
    end else begin : g_layer2
        logic [(2**(SEL_WIDTH-1))-1:0] layer_out;

        for (genvar k = 0; k < 2**(SEL_WIDTH-1); k++) begin : g_mux2
            assign layer_out[k] = sel[0] ? in[2*k+1] : in[2*k];
        end

        if (SEL_WIDTH == 1) begin : g_leaf
            assign out = layer_out[0];
        end else begin : g_next
            mux_tree_bit #(
                .SEL_WIDTH(SEL_WIDTH-1)
            ) sub_i (
                .in (layer_out),
                .sel(sel[SEL_WIDTH-1:1]),
                .out(out)
            );
        end
    end

endmodule

// File: logic/operand_fetch.sv
`timescale 1ns/1ps

`include "operand_fetch_defines.svh"

// operand fetch stage: register read, bypass, one output pipeline register
module operand_fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  operand_pkg::operand_req_t   req,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  operand_pkg::fwd_t           ex_fwd,
    input  operand_pkg::fwd_t           wb,
    output operand_pkg::operand_bundle_t bundle,
    output logic                        bundle_valid,
    input  logic                        bundle_ready
);

    import operand_pkg::*;

    // ########################################
    // register read
    // ########################################

    logic [`OF_DATA_W-1:0] rdata_a;
    logic [`OF_DATA_W-1:0] rdata_b;

    register_file rf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb),
        .raddr_a(req.src_a),
        .raddr_b(req.src_b),
        .rdata_a(rdata_a),
        .rdata_b(rdata_b)
    );

    // ########################################
    // opcode decode for operand b
    // ########################################

    logic                  alt_en_b;
    logic [`OF_DATA_W-1:0] alt_data_b;

    always_comb begin
        alt_en_b   = 1'b0;
        alt_data_b = '0;
        case (req.opcode)
            op_imm: begin
                alt_en_b   = 1'b1;
                alt_data_b = req.imm;
            end
            // mov reads zero as its second operand
            op_mov: alt_en_b = 1'b1;
            default: alt_en_b = 1'b0;
        endcase
    end

    // ########################################
    // bypass
    // ########################################

    logic [`OF_DATA_W-1:0] operand_a;
    logic [`OF_DATA_W-1:0] operand_b;

    bypass_select byp_a_i (
        .src     (req.src_a),
        .ex_fwd  (ex_fwd),
        .wb      (wb),
        .rf_data (rdata_a),
        .alt_en  (1'b0),
        .alt_data('0),
        .operand (operand_a)
    );

    bypass_select byp_b_i (
        .src     (req.src_b),
        .ex_fwd  (ex_fwd),
        .wb      (wb),
        .rf_data (rdata_b),
        .alt_en  (alt_en_b),
        .alt_data(alt_data_b),
        .operand (operand_b)
    );

    // ########################################
    // output register and handshake
    // ########################################

    stage_state_e state_q;
    stage_state_e state_d;
    logic         accept;

    // a full stage still accepts when its bundle leaves this edge
    assign req_ready    = (state_q == stage_empty) || bundle_ready;
    assign accept       = req_valid && req_ready;
    assign bundle_valid = (state_q == stage_full);

    always_comb begin
        state_d = state_q;
        case (state_q)
            stage_empty: if (accept) state_d = stage_full;
            stage_full:  if (bundle_ready && !accept) state_d = stage_empty;
            default:     state_d = stage_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= stage_empty;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bundle <= '0;
        end else if (accept) begin
            bundle.opcode <= req.opcode;
            bundle.dst    <= req.dst;
            bundle.a      <= operand_a;
            bundle.b      <= operand_b;
        end
    end

endmodule

// File: logic/operand_pkg.sv
`include "operand_fetch_defines.svh"

package operand_pkg;

    // ########################################
    // enums
    // ########################################

    // instruction class as seen by operand fetch
    typedef enum logic [1:0] {
        op_alu = 2'd0,
        op_imm = 2'd1,
        op_mov = 2'd2
    } opcode_e;

    // occupancy of the output pipeline register
    typedef enum logic {
        stage_empty = 1'b0,
        stage_full  = 1'b1
    } stage_state_e;

    // ########################################
    // structs
    // ########################################

    // instruction request from decode, 43 bits
    typedef struct packed {
        opcode_e                  opcode;
        logic [`OF_REG_ADDR_W-1:0] src_a;
        logic [`OF_REG_ADDR_W-1:0] src_b;
        logic [`OF_REG_ADDR_W-1:0] dst;
        logic [`OF_DATA_W-1:0]     imm;
    } operand_req_t;

    // result forward, used for both execute and writeback, 36 bits
    typedef struct packed {
        logic                      valid;
        logic [`OF_REG_ADDR_W-1:0] dst;
        logic [`OF_DATA_W-1:0]     data;
    } fwd_t;

    // operands handed to execute, 69 bits
    typedef struct packed {
        opcode_e                   opcode;
        logic [`OF_REG_ADDR_W-1:0] dst;
        logic [`OF_DATA_W-1:0]     a;
        logic [`OF_DATA_W-1:0]     b;
    } operand_bundle_t;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps

`include "operand_fetch_defines.svh"

// 8 x 32 register file, one write port from writeback, two tree mux read ports
module register_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  operand_pkg::fwd_t         wb,
    input  logic [`OF_REG_ADDR_W-1:0] raddr_a,
    input  logic [`OF_REG_ADDR_W-1:0] raddr_b,
    output logic [`OF_DATA_W-1:0]     rdata_a,
    output logic [`OF_DATA_W-1:0]     rdata_b
);

    // ########################################
    // storage
    // ########################################

    // register 0 is not stored
    logic [`OF_DATA_W-1:0] regs [1:`OF_NUM_REGS-1];

    logic wr_en;

    assign wr_en = wb.valid && (wb.dst != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 1; r < `OF_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dst] <= wb.data;
        end
    end

    // ########################################
    // read ports
    // ########################################

    logic [`OF_NUM_REGS*`OF_DATA_W-1:0] read_vec;

    // word 0 is hard zero
    assign read_vec[0 +: `OF_DATA_W] = '0;

    for (genvar k = 1; k < `OF_NUM_REGS; k++) begin : g_flatten
        assign read_vec[k*`OF_DATA_W +: `OF_DATA_W] = regs[k];
    end

    mux_tree #(
        .SEL_WIDTH (`OF_REG_ADDR_W),
        .DATA_WIDTH(`OF_DATA_W)
    ) read_a_i (
        .in (read_vec),
        .sel(raddr_a),
        .out(rdata_a)
    );

    mux_tree #(
        .SEL_WIDTH (`OF_REG_ADDR_W),
        .DATA_WIDTH(`OF_DATA_W)
    ) read_b_i (
        .in (read_vec),
        .sel(raddr_b),
        .out(rdata_b)
    );

endmodule

// File: operand_fetch.f
+incdir+include
logic/operand_pkg.sv
logic/mux_tree.sv
logic/mux_onehot.sv
logic/register_file.sv
logic/bypass_select.sv
logic/operand_fetch.sv
testbench/tb_operand_fetch.sv

// File: testbench/tb_operand_fetch.sv
`timescale 1ns/1ps

`include "operand_fetch_defines.svh"

module tb_operand_fetch;

    import operand_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int REG_W       = `OF_REG_ADDR_W;
    localparam int RANDOM_REQS = 400;

    logic            clk;
    logic            rst_n;
    operand_req_t    req;
    logic            req_valid;
    logic            req_ready;
    fwd_t            ex_fwd;
    fwd_t            wb;
    operand_bundle_t bundle;
    logic            bundle_valid;
    logic            bundle_ready;

    logic [`OF_DATA_W-1:0] ref_regs [`OF_NUM_REGS];
    operand_bundle_t       exp_q [$];
    operand_bundle_t       exp_head;
    operand_bundle_t       prev_bundle;
    int                    accepts;
    int                    transfers;
    int                    mismatch_errors;
    int                    protocol_errors;
    logic                  stall_on;
    string                 test_name;

    operand_fetch dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .ex_fwd      (ex_fwd),
        .wb          (wb),
        .bundle      (bundle),
        .bundle_valid(bundle_valid),
        .bundle_ready(bundle_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // hang guard, well above the length of all phases
    initial begin
        #(2000*CLK_PERIOD);
        $display("watchdog expired: the run did not finish within 2000 clock cycles");
        $display("TEST FAILED");
        $finish;
    end

    // ########################################
    // reference model
    // ########################################

    function automatic logic [`OF_DATA_W-1:0] pick_operand(
        input logic [REG_W-1:0] src,
        input fwd_t             ex,
        input fwd_t             w
    );
        if (src == '0) begin
            return '0;
        end
        if (ex.valid && ex.dst == src) begin
            return ex.data;
        end
        if (w.valid && w.dst == src) begin
            return w.data;
        end
        return ref_regs[src];
    endfunction

    // predicts on accept, retires on transfer, then applies the writeback
    always @(posedge clk) begin
        operand_bundle_t expected;
        if (rst_n) begin
            prev_bundle = bundle;
            if (bundle_valid && bundle_ready) begin
                transfers++;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end else begin
                    protocol_errors++;
                    $display("a bundle transferred while no request was outstanding");
                end
            end
            if (req_valid && req_ready) begin
                accepts++;
                expected.opcode = req.opcode;
                expected.dst    = req.dst;
                expected.a      = pick_operand(req.src_a, ex_fwd, wb);
                case (req.opcode)
                    op_imm:  expected.b = req.imm;
                    op_mov:  expected.b = '0;
                    default: expected.b = pick_operand(req.src_b, ex_fwd, wb);
                endcase
                exp_q.push_back(expected);
            end
            if (wb.valid && wb.dst != '0) begin
                ref_regs[wb.dst] = wb.data;
            end
        end
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // ########################################
    // checks
    // ########################################

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        (bundle_valid && bundle_ready) |-> (bundle == exp_head))
    else begin
        mismatch_errors++;
        $display("error %s bundle: expected %h actual %h",
                 test_name, $sampled(exp_head), $sampled(bundle));
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) |=> bundle_valid)
    else begin
        mismatch_errors++;
        $display("error %s bundle_valid after accept: expected 1 actual %b",
                 test_name, $sampled(bundle_valid));
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bundle_valid && !bundle_ready) |=> (bundle_valid && bundle == prev_bundle))
    else begin
        mismatch_errors++;
        $display("error %s stalled bundle: expected %h actual %h (valid %b)",
                 test_name, $sampled(prev_bundle), $sampled(bundle), $sampled(bundle_valid));
    end

    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        (bundle_valid && !bundle_ready) |-> !req_ready)
    else begin
        mismatch_errors++;
        $display("error %s req_ready under stall: expected 0 actual %b",
                 test_name, $sampled(req_ready));
    end

    a_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!bundle_valid && req_ready))
    else begin
        mismatch_errors++;
        $display("error %s valid/ready after reset: expected 01 actual %b%b",
                 test_name, $sampled(bundle_valid), $sampled(req_ready));
    end

    // ########################################
    // stimulus
    // ########################################

    always @(negedge clk) begin
        if (stall_on) begin
            bundle_ready = ($urandom_range(0, 3) != 0);
        end else if (accepts == 0) begin
            // ready stays low until the first accept
            // so req_ready after reset can only come from the empty stage
            bundle_ready = 1'b0;
        end else begin
            bundle_ready = 1'b1;
        end
    end

    function automatic operand_req_t make_req(
        input opcode_e          op,
        input logic [REG_W-1:0] src_a,
        input logic [REG_W-1:0] src_b,
        input logic [REG_W-1:0] dst,
        input logic [31:0]      imm
    );
        operand_req_t r;
        r.opcode = op;
        r.src_a  = src_a;
        r.src_b  = src_b;
        r.dst    = dst;
        r.imm    = imm;
        return r;
    endfunction

    function automatic fwd_t make_fwd(input logic [REG_W-1:0] dst, input logic [31:0] data);
        fwd_t f;
        f.valid = 1'b1;
        f.dst   = dst;
        f.data  = data;
        return f;
    endfunction

    // holds the request until the DUT takes it, returns on a falling edge
    task automatic issue(input operand_req_t r, input fwd_t ex, input fwd_t w);
        int seen;
        seen      = accepts;
        req       = r;
        req_valid = 1'b1;
        ex_fwd    = ex;
        wb        = w;
        @(negedge clk);
        while (accepts == seen) begin
            @(negedge clk);
        end
        req_valid = 1'b0;
        ex_fwd    = '0;
        wb        = '0;
    endtask

    task automatic write_reg(input logic [REG_W-1:0] dst, input logic [31:0] data);
        wb = make_fwd(dst, data);
        @(negedge clk);
        wb = '0;
    endtask

    task automatic random_traffic(output operand_req_t r, output fwd_t ex, output fwd_t w);
        r.opcode = opcode_e'($urandom_range(0, 2));
        r.src_a  = REG_W'($urandom_range(0, `OF_NUM_REGS-1));
        r.src_b  = REG_W'($urandom_range(0, `OF_NUM_REGS-1));
        r.dst    = REG_W'($urandom_range(0, `OF_NUM_REGS-1));
        r.imm    = $urandom();
        // aim forwards at the sources often enough to hit
        ex.valid = $urandom_range(0, 1);
        ex.dst   = ($urandom_range(0, 1) == 1) ? r.src_a : r.src_b;
        ex.data  = $urandom();
        w.valid  = $urandom_range(0, 1);
        w.dst    = ($urandom_range(0, 1) == 1) ? r.src_b : REG_W'($urandom_range(0, 7));
        w.data   = $urandom();
    endtask

    initial begin
        operand_req_t     r;
        fwd_t             ex;
        fwd_t             w;
        logic [REG_W-1:0] s;

        void'($urandom(32'hcf23_ac03));
        rst_n           = 1'b0;
        req             = '0;
        req_valid       = 1'b0;
        ex_fwd          = '0;
        wb              = '0;
        bundle_ready    = 1'b0;
        stall_on        = 1'b0;
        accepts         = 0;
        transfers       = 0;
        mismatch_errors = 0;
        protocol_errors = 0;
        test_name       = "reset";
        for (int k = 0; k < `OF_NUM_REGS; k++) begin
            ref_regs[k] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset_reads";
        for (int k = 0; k < `OF_NUM_REGS; k++) begin
            issue(make_req(op_alu, REG_W'(k), REG_W'(`OF_NUM_REGS-1-k), 3'd1, 32'h0), '0, '0);
        end

        test_name = "rf_path";
        for (int k = 0; k < `OF_NUM_REGS; k++) begin
            write_reg(REG_W'(k), $urandom());
        end
        // register 0 was written above and must still read zero
        issue(make_req(op_alu, 3'd0, 3'd0, 3'd2, 32'h0), '0, '0);
        for (int k = 0; k < 2*`OF_NUM_REGS; k++) begin
            r = make_req(op_alu, REG_W'($urandom_range(0, 7)), REG_W'(k), 3'd3, 32'h0);
            issue(r, '0, '0);
        end

        test_name = "bypass";
        issue(make_req(op_alu, 3'd3, 3'd5, 3'd2, 32'h0),
              make_fwd(3'd3, 32'haaaa_0003), make_fwd(3'd3, 32'hbbbb_0003));
        // only writeback matches, and the same write lands in the file
        issue(make_req(op_alu, 3'd4, 3'd4, 3'd2, 32'h0), '0, make_fwd(3'd4, 32'hbbbb_0004));
        issue(make_req(op_alu, 3'd6, 3'd7, 3'd2, 32'h0),
              make_fwd(3'd7, 32'haaaa_0007), make_fwd(3'd6, 32'hbbbb_0006));
        issue(make_req(op_alu, 3'd0, 3'd0, 3'd2, 32'h0),
              make_fwd(3'd0, 32'haaaa_0000), make_fwd(3'd0, 32'hbbbb_0000));
        issue(make_req(op_alu, 3'd4, 3'd1, 3'd2, 32'h0), '0, '0);

        test_name = "imm_mov";
        for (int k = 0; k < `OF_NUM_REGS; k++) begin
            s = REG_W'(k);
            r = make_req((k % 2 == 1) ? op_mov : op_imm, s, s, 3'd5, 32'h5a00_0000 + k);
            issue(r, make_fwd(s, 32'hcccc_0000 + k), make_fwd(s, 32'hdddd_0000 + k));
        end

        test_name = "backpressure";
        stall_on = 1'b1;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            random_traffic(r, ex, w);
            if ($urandom_range(0, 4) == 0) begin
                // idle cycle that only writes back
                wb = w;
                @(negedge clk);
                wb = '0;
            end else begin
                issue(r, ex, w);
            end
        end
        stall_on = 1'b0;

        test_name = "drain";
        while (exp_q.size() != 0 || bundle_valid) begin
            @(negedge clk);
        end

        if (accepts != transfers) begin
            protocol_errors++;
            $display("error %s accept count vs transfer count: expected %0d actual %0d",
                     test_name, accepts, transfers);
        end
        $display("errors: %0d value mismatches, %0d protocol failures (%0d accepts, %0d transfers)",
                 mismatch_errors, protocol_errors, accepts, transfers);
        if (mismatch_errors + protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
